/* Makefile */
TOOL       = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing
TOP        = tb_cr16_core
FILELIST   = cr16_core.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TESTS FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* cr16_core.f */
rtl/cr16_arch_pkg.sv
rtl/cr16_isa_pkg.sv
rtl/cr16_alu.sv
rtl/cr16_decoder.sv
rtl/cr16_regfile.sv
rtl/cr16_pc.sv
rtl/cr16_mem_port.sv
rtl/cr16_control.sv
rtl/cr16_core.sv
testbench/tb_cr16_core.sv

/* rtl/cr16_alu.sv */
// Arithmetic and logic unit
module cr16_alu
    import cr16_arch_pkg::*;
    import cr16_isa_pkg::*;
(
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result,
    output flags_t  flags
);
    logic [16:0] sum;

    always_comb begin
        sum    = '0;
        result = '0;
        flags  = '0;
        case (op)
            ALU_ADD: begin
                sum           = {1'b0, a} + {1'b0, b};
                result        = sum[15:0];
                flags[FLAG_C] = sum[16];
                // Operands agree in sign but the sum does not
                flags[FLAG_F] = (a[15] == b[15]) && (result[15] != a[15]);
            end
            ALU_SUB: begin
                sum           = {1'b0, a} - {1'b0, b};
                result        = sum[15:0];
                // Bit 16 is the borrow out
                flags[FLAG_C] = sum[16];
                flags[FLAG_F] = (a[15] != b[15]) && (result[15] != a[15]);
                flags[FLAG_L] = a < b;
                flags[FLAG_N] = $signed(a) < $signed(b);
            end
            ALU_AND: result = a & b;
            ALU_OR: result = a | b;
            ALU_XOR: result = a ^ b;
            default: result = b;
        endcase
        flags[FLAG_Z] = (result == '0);
    end

endmodule

/* rtl/cr16_arch_pkg.sv */
// CR16 machine types
package cr16_arch_pkg;

    // Data word and memory address share one width
    typedef logic [15:0] word_t;

    // Index into the sixteen general registers
    typedef logic [3:0] reg_idx_t;

    // Status flags packed N Z F L C, carry in bit 0
    typedef logic [4:0] flags_t;

    localparam integer FLAG_C = 0;
    localparam integer FLAG_L = 1;
    localparam integer FLAG_F = 2;
    localparam integer FLAG_Z = 3;
    localparam integer FLAG_N = 4;

    // Sequencing states of the control FSM
    typedef enum logic [3:0] {
        ST_FETCH      = 4'd0,
        ST_FETCH_WAIT = 4'd1,
        ST_DECODE     = 4'd2,
        ST_EXEC       = 4'd3,
        ST_MEM        = 4'd4,
        ST_MEM_WAIT   = 4'd5
    } ctrl_state_t;

endpackage

/* rtl/cr16_control.sv */
// Instruction sequencing FSM
module cr16_control
    import cr16_arch_pkg::*;
(
    input  logic   I_CLK,
    input  logic   I_NRESET,
    input  logic   is_alu,
    input  logic   uses_imm,
    input  logic   writes_flags,
    input  logic   writes_reg,
    input  logic   is_mov,
    input  logic   is_load,
    input  logic   is_store,
    input  logic   is_branch,
    input  logic   branch_taken,
    input  word_t  alu_result,
    input  flags_t alu_flags,
    input  word_t  imm,
    input  word_t  reg_a,
    input  word_t  reg_b,
    input  logic   mem_done,
    input  word_t  mem_rdata,
    input  word_t  pc,
    output word_t  instr,
    output logic   mem_start,
    output logic   mem_write,
    output word_t  mem_target,
    output word_t  mem_data,
    output logic   reg_we,
    output word_t  wr_data,
    output logic   pc_inc,
    output logic   pc_branch,
    output flags_t status_flags
);
    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        load_done;

    always_ff @(posedge I_CLK or negedge I_NRESET) begin
        if (!I_NRESET) begin
            state        <= ST_FETCH;
            instr        <= '0;
            status_flags <= '0;
        end else begin
            state <= state_next;
            if (state == ST_FETCH_WAIT && mem_done) begin
                instr <= mem_rdata;
            end
            // Only arithmetic and compare touch the flags
            if (state == ST_EXEC && is_alu && writes_flags) begin
                status_flags <= alu_flags;
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_FETCH: state_next = ST_FETCH_WAIT;
            ST_FETCH_WAIT: begin
                if (mem_done) begin
                    state_next = ST_DECODE;
                end
            end
            ST_DECODE: state_next = ST_EXEC;
            ST_EXEC: state_next = (is_load || is_store) ? ST_MEM : ST_FETCH;
            ST_MEM: state_next = ST_MEM_WAIT;
            ST_MEM_WAIT: begin
                if (mem_done) begin
                    state_next = ST_FETCH;
                end
            end
            default: state_next = ST_FETCH;
        endcase
    end

    // Fetch from PC, load from Rsrc, store Rsrc to the address in Rdest
    assign mem_start  = (state == ST_FETCH) || (state == ST_MEM);
    assign mem_write  = (state == ST_MEM) && is_store;
    assign mem_target = (state == ST_MEM) ? (is_store ? reg_b : reg_a) : pc;
    assign mem_data   = reg_a;

    assign pc_inc    = (state == ST_FETCH_WAIT) && mem_done;
    assign pc_branch = (state == ST_EXEC) && is_branch && branch_taken;

    assign load_done = (state == ST_MEM_WAIT) && mem_done;
    assign reg_we    = ((state == ST_EXEC) && writes_reg && !is_load) || (load_done && is_load);

    always_comb begin
        if (load_done && is_load) begin
            wr_data = mem_rdata;
        end else if (is_mov && uses_imm) begin
            wr_data = imm;
        end else begin
            wr_data = alu_result;
        end
    end

    // A completion only arrives while the FSM waits for one
    a_done_state: assert property (@(posedge I_CLK) disable iff (!I_NRESET)
        mem_done |-> (state == ST_FETCH_WAIT || state == ST_MEM_WAIT));

endmodule

/* rtl/cr16_core.sv */
// CR16 core top level
module cr16_core
    import cr16_arch_pkg::*;
    import cr16_isa_pkg::*;
#(
    parameter word_t P_RESET_VECTOR = 16'h0000
) (
    input  logic   I_CLK,
    input  logic   I_NRESET,
    input  logic   mem_ack,
    input  word_t  mem_rdata,
    output logic   mem_req,
    output logic   mem_we,
    output word_t  mem_addr,
    output word_t  mem_wdata,
    output flags_t status_flags
);
    word_t    instr;
    reg_idx_t rdest;
    reg_idx_t rsrc;
    alu_op_t  alu_op;
    word_t    imm;
    word_t    disp;
    logic     uses_imm, is_alu, writes_flags, writes_reg;
    logic     is_mov, is_load, is_store, is_branch, branch_taken;
    word_t    reg_a;
    word_t    reg_b;
    word_t    alu_b;
    word_t    alu_result;
    flags_t   alu_flags;
    word_t    pc;
    logic     pc_inc, pc_branch;
    logic     mem_start, mem_write, mem_done;
    word_t    mem_target;
    word_t    mem_data;
    word_t    port_rdata;
    logic     reg_we;
    word_t    wr_data;

    // Second ALU operand is Rsrc or the extended immediate
    assign alu_b = uses_imm ? imm : reg_a;

    cr16_control u_control (.mem_rdata(port_rdata), .*);

    cr16_decoder u_decoder (.flags(status_flags), .*);

    cr16_alu u_alu (
        .op(alu_op), .a(reg_b), .b(alu_b),
        .result(alu_result), .flags(alu_flags)
    );

    cr16_regfile u_regfile (
        .we(reg_we), .waddr(rdest), .wdata(wr_data),
        .raddr_a(rsrc), .raddr_b(rdest),
        .rdata_a(reg_a), .rdata_b(reg_b), .*
    );

    cr16_pc #(.P_RESET_VECTOR(P_RESET_VECTOR)) u_pc (
        .inc(pc_inc), .branch(pc_branch), .*
    );

    cr16_mem_port u_mem_port (
        .start(mem_start), .write(mem_write), .target(mem_target), .data(mem_data),
        .done(mem_done), .rdata(port_rdata), .*
    );

endmodule

/* rtl/cr16_decoder.sv */
// Instruction decoder
module cr16_decoder
    import cr16_arch_pkg::*;
    import cr16_isa_pkg::*;
(
    input  word_t    instr,
    input  flags_t   flags,
    output reg_idx_t rdest,
    output reg_idx_t rsrc,
    output alu_op_t  alu_op,
    output word_t    imm,
    output logic     uses_imm,
    output logic     is_alu,
    output logic     writes_flags,
    output logic     writes_reg,
    output logic     is_mov,
    output logic     is_load,
    output logic     is_store,
    output logic     is_branch,
    output logic     branch_taken,
    output word_t    disp
);
    opcode_t    opcode;
    ext_t       ext;
    logic [7:0] imm8;
    logic       is_cmp;

    assign opcode = instr[15:12];
    assign ext    = instr[7:4];
    assign imm8   = instr[7:0];
    assign rdest  = instr[11:8];
    assign rsrc   = instr[3:0];
    assign disp   = {{8{imm8[7]}}, imm8};

    always_comb begin
        alu_op = ALU_PASS;
        is_alu = 1'b1;
        case (opcode)
            OP_EXT: begin
                case (ext)
                    EXT_ADD: alu_op = ALU_ADD;
                    EXT_SUB, EXT_CMP: alu_op = ALU_SUB;
                    EXT_AND: alu_op = ALU_AND;
                    EXT_OR: alu_op = ALU_OR;
                    EXT_XOR: alu_op = ALU_XOR;
                    default: is_alu = 1'b0;
                endcase
            end
            OP_ADDI: alu_op = ALU_ADD;
            OP_SUBI, OP_CMPI: alu_op = ALU_SUB;
            OP_ANDI: alu_op = ALU_AND;
            OP_ORI: alu_op = ALU_OR;
            OP_XORI: alu_op = ALU_XOR;
            default: is_alu = 1'b0;
        endcase
    end

    // Arithmetic immediates are signed, logic and MOVIL are not
    always_comb begin
        case (opcode)
            OP_ADDI, OP_SUBI, OP_CMPI: imm = {{8{imm8[7]}}, imm8};
            OP_MOVIU: imm = {imm8, 8'h00};
            default: imm = {8'h00, imm8};
        endcase
    end

    assign is_cmp    = (opcode == OP_CMPI) || (opcode == OP_EXT && ext == EXT_CMP);
    assign is_mov    = (opcode == OP_MEM && ext == EXT_MOV) || opcode == OP_MOVIL
                       || opcode == OP_MOVIU;
    assign is_load   = (opcode == OP_MEM) && (ext == EXT_LOAD);
    assign is_store  = (opcode == OP_MEM) && (ext == EXT_STORE);
    assign is_branch = (opcode == OP_BCOND);
    assign uses_imm  = (is_alu && opcode != OP_EXT) || opcode == OP_MOVIL
                       || opcode == OP_MOVIU;

    assign writes_flags = is_alu && (alu_op == ALU_ADD || alu_op == ALU_SUB);
    assign writes_reg   = (is_alu && !is_cmp) || is_mov || is_load;

    always_comb begin
        case (cond_t'(rdest))
            COND_EQ: branch_taken = flags[FLAG_Z];
            COND_NE: branch_taken = !flags[FLAG_Z];
            COND_CS: branch_taken = flags[FLAG_C];
            COND_CC: branch_taken = !flags[FLAG_C];
            COND_FS: branch_taken = flags[FLAG_F];
            COND_FC: branch_taken = !flags[FLAG_F];
            COND_LO: branch_taken = flags[FLAG_L];
            COND_HS: branch_taken = !flags[FLAG_L];
            COND_LT: branch_taken = flags[FLAG_N];
            COND_GE: branch_taken = !flags[FLAG_N];
            COND_UC: branch_taken = 1'b1;
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

/* rtl/cr16_isa_pkg.sv */
// CR16 instruction encodings
package cr16_isa_pkg;

    // Major opcode in bits 15:12, extension in bits 7:4
    typedef logic [3:0] opcode_t;
    typedef logic [3:0] ext_t;

    // Branch condition held in bits 11:8 of B_COND
    typedef enum logic [3:0] {
        COND_EQ = 4'b0000,
        COND_NE = 4'b0001,
        COND_CS = 4'b0010,
        COND_CC = 4'b0011,
        COND_FS = 4'b0100,
        COND_FC = 4'b0101,
        COND_LT = 4'b0110,
        COND_LO = 4'b1000,
        COND_GE = 4'b1011,
        COND_HS = 4'b1101,
        COND_UC = 4'b1110
    } cond_t;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_PASS = 3'd5
    } alu_op_t;

    // Register-register group and the immediate opcodes
    localparam opcode_t OP_EXT   = 4'b0000;
    localparam opcode_t OP_ADDI  = 4'b0001;
    localparam opcode_t OP_SUBI  = 4'b0100;
    localparam opcode_t OP_CMPI  = 4'b0101;
    localparam opcode_t OP_ANDI  = 4'b0111;
    localparam opcode_t OP_ORI   = 4'b1000;
    localparam opcode_t OP_XORI  = 4'b1001;
    localparam opcode_t OP_MOVIL = 4'b1010;
    localparam opcode_t OP_MOVIU = 4'b1011;
    localparam opcode_t OP_BCOND = 4'b1100;
    // Move and memory group
    localparam opcode_t OP_MEM   = 4'b1111;

    localparam ext_t EXT_ADD   = 4'b0000;
    localparam ext_t EXT_SUB   = 4'b0011;
    localparam ext_t EXT_CMP   = 4'b0100;
    localparam ext_t EXT_AND   = 4'b0110;
    localparam ext_t EXT_OR    = 4'b0111;
    localparam ext_t EXT_XOR   = 4'b1000;
    localparam ext_t EXT_MOV   = 4'b0001;
    localparam ext_t EXT_LOAD  = 4'b1010;
    localparam ext_t EXT_STORE = 4'b1011;

endpackage

/* rtl/cr16_mem_port.sv */
// Four-phase memory master
module cr16_mem_port
    import cr16_arch_pkg::*;
(
    input  logic  I_CLK,
    input  logic  I_NRESET,
    input  logic  start,
    input  logic  write,
    input  word_t target,
    input  word_t data,
    output logic  done,
    output word_t rdata,
    output logic  mem_req,
    output logic  mem_we,
    output word_t mem_addr,
    output word_t mem_wdata,
    input  logic  mem_ack,
    input  word_t mem_rdata
);
    logic pend;

    always_ff @(posedge I_CLK or negedge I_NRESET) begin
        if (!I_NRESET) begin
            pend    <= 1'b0;
            mem_req <= 1'b0;
            mem_we  <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                pend   <= 1'b1;
                mem_we <= write;
            end else if (pend && !mem_ack) begin
                // Previous handshake fully closed
                pend    <= 1'b0;
                mem_req <= 1'b1;
            end else if (mem_req && mem_ack) begin
                mem_req <= 1'b0;
                mem_we  <= 1'b0;
                done    <= 1'b1;
            end
        end
    end

    always_ff @(posedge I_CLK) begin
        if (start) begin
            mem_addr  <= target;
            mem_wdata <= data;
        end
        // Read word stays put until the next acknowledged request
        if (mem_req && mem_ack) begin
            rdata <= mem_rdata;
        end
    end

    a_req_stable: assert property (@(posedge I_CLK) disable iff (!I_NRESET)
        mem_req && !mem_ack |=> $stable(mem_addr) && $stable(mem_we));

    a_no_overlap: assert property (@(posedge I_CLK) disable iff (!I_NRESET)
        start |-> !pend && !mem_req);

endmodule

/* rtl/cr16_pc.sv */
// Program counter
module cr16_pc
    import cr16_arch_pkg::*;
#(
    parameter word_t P_RESET_VECTOR = 16'h0000
) (
    input  logic  I_CLK,
    input  logic  I_NRESET,
    input  logic  inc,
    input  logic  branch,
    input  word_t disp,
    output word_t pc
);
    // Branch offset applies to the PC already stepped past the branch
    always_ff @(posedge I_CLK or negedge I_NRESET) begin
        if (!I_NRESET) begin
            pc <= P_RESET_VECTOR;
        end else if (inc) begin
            pc <= pc + 16'd1;
        end else if (branch) begin
            pc <= pc + disp;
        end
    end

    a_single_update: assert property (@(posedge I_CLK) disable iff (!I_NRESET)
        !(inc && branch));

endmodule

/* rtl/cr16_regfile.sv */
// General register file
module cr16_regfile
    import cr16_arch_pkg::*;
(
    input  logic     I_CLK,
    input  logic     I_NRESET,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata,
    input  reg_idx_t raddr_a,
    input  reg_idx_t raddr_b,
    output word_t    rdata_a,
    output word_t    rdata_b
);
    word_t regs [16];

    always_ff @(posedge I_CLK or negedge I_NRESET) begin
        if (!I_NRESET) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Reads see the old value during a write cycle
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

endmodule

/* testbench/tb_cr16_core.sv */
// CR16 core testbench
module tb_cr16_core
    import cr16_arch_pkg::*;
    import cr16_isa_pkg::*;
;
    localparam word_t RESET_VECTOR = 16'h0000;
    localparam int    N_INSTR      = 2000;
    localparam int    CYCLE_LIMIT  = N_INSTR * 12;

    logic   I_CLK = 1'b0;
    logic   I_NRESET = 1'b0;
    logic   mem_ack = 1'b0;
    word_t  mem_rdata = 16'h0000;
    logic   mem_req;
    logic   mem_we;
    word_t  mem_addr;
    word_t  mem_wdata;
    flags_t status_flags;

    // Reference state of the ISA model
    word_t    model_regs [16];
    word_t    model_pc = RESET_VECTOR;
    flags_t   model_flags = '0;
    logic     load_pending = 1'b0;
    logic     store_pending = 1'b0;
    reg_idx_t pend_rd;
    reg_idx_t pend_rs;

    logic [31:0] lfsr_state = 32'h896b;
    logic        req_seen = 1'b0;
    logic [1:0]  ack_wait = 2'd0;
    logic [1:0]  drop_wait = 2'd0;
    word_t       req_addr;
    word_t       resp_word = 16'h0000;
    int          fetch_count = 0;
    int          cycle_count = 0;
    int          mismatch_count = 0;
    int          protocol_count = 0;

    ext_t    reg_exts [6] = '{EXT_ADD, EXT_SUB, EXT_CMP, EXT_AND, EXT_OR, EXT_XOR};
    opcode_t imm_opcodes [6] = '{OP_ADDI, OP_SUBI, OP_CMPI, OP_ANDI, OP_ORI, OP_XORI};
    cond_t   cond_list [11] = '{COND_EQ, COND_NE, COND_CS, COND_CC, COND_FS, COND_FC,
                                COND_LO, COND_HS, COND_LT, COND_GE, COND_UC};

    cr16_core #(.P_RESET_VECTOR(RESET_VECTOR)) u_dut (
        .I_CLK(I_CLK), .I_NRESET(I_NRESET), .mem_ack(mem_ack), .mem_rdata(mem_rdata),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .status_flags(status_flags)
    );

    always #2 I_CLK = ~I_CLK;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t take_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_addr(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_flags(input string name, input flags_t got, input flags_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        protocol_count++;
        $display("ERROR t=%0t %s", $time, what);
    endtask

    task automatic print_error_counts();
        $display("Error counts: %0d mismatches, %0d protocol failures",
                 mismatch_count, protocol_count);
    endtask

    function automatic logic cond_taken(input cond_t cond, input flags_t f);
        logic taken;
        case (cond)
            COND_EQ: taken = f[FLAG_Z];
            COND_NE: taken = !f[FLAG_Z];
            COND_CS: taken = f[FLAG_C];
            COND_CC: taken = !f[FLAG_C];
            COND_FS: taken = f[FLAG_F];
            COND_FC: taken = !f[FLAG_F];
            COND_LO: taken = f[FLAG_L];
            COND_HS: taken = !f[FLAG_L];
            COND_LT: taken = f[FLAG_N];
            COND_GE: taken = !f[FLAG_N];
            default: taken = 1'b1;
        endcase
        return taken;
    endfunction

    // Operation index follows reg_exts: add, sub, cmp, and, or, xor
    task automatic apply_alu(input int op, input reg_idx_t rd, input word_t b);
        word_t  a;
        word_t  res;
        flags_t fl;
        int     ua;
        int     ub;
        int     sa;
        int     sb;
        a  = model_regs[rd];
        ua = int'(a);
        ub = int'(b);
        sa = int'($signed(a));
        sb = int'($signed(b));
        fl = '0;
        case (op)
            0: begin
                res = a + b;
                fl[FLAG_C] = (ua + ub) > 65535;
                fl[FLAG_F] = (sa + sb) > 32767 || (sa + sb) < -32768;
            end
            1, 2: begin
                res = a - b;
                fl[FLAG_C] = ua < ub;
                fl[FLAG_L] = ua < ub;
                fl[FLAG_N] = sa < sb;
                fl[FLAG_F] = (sa - sb) > 32767 || (sa - sb) < -32768;
            end
            3: res = a & b;
            4: res = a | b;
            default: res = a ^ b;
        endcase
        fl[FLAG_Z] = (res == 16'h0000);
        if (op <= 2) begin
            model_flags = fl;
        end
        if (op != 2) begin
            model_regs[rd] = res;
        end
    endtask

    // Builds one random instruction and runs it on the model
    task automatic issue_instruction(output word_t instr);
        int         kind;
        int         idx;
        word_t      bits;
        reg_idx_t   rd;
        reg_idx_t   rs;
        logic [7:0] imm8;
        word_t      b;
        bits = take_bits(4);
        rd   = bits[3:0];
        bits = take_bits(4);
        rs   = bits[3:0];
        bits = take_bits(8);
        imm8 = bits[7:0];
        kind = int'(take_bits(4));
        idx  = int'(take_bits(3)) % 6;
        model_pc = model_pc + 16'd1;
        if (kind < 2) begin
            instr = {OP_EXT, rd, reg_exts[idx], rs};
            apply_alu(idx, rd, model_regs[rs]);
        end else if (kind < 5) begin
            b = (idx < 3) ? {{8{imm8[7]}}, imm8} : {8'h00, imm8};
            instr = {imm_opcodes[idx], rd, imm8};
            apply_alu(idx, rd, b);
        end else if (kind == 5) begin
            instr = {OP_MEM, rd, EXT_MOV, rs};
            model_regs[rd] = model_regs[rs];
        end else if (kind == 6) begin
            instr = {OP_MOVIL, rd, imm8};
            model_regs[rd] = {8'h00, imm8};
        end else if (kind == 7) begin
            instr = {OP_MOVIU, rd, imm8};
            model_regs[rd] = {imm8, 8'h00};
        end else if (kind < 10) begin
            // Displacement kept within -8 to +7
            idx  = int'(take_bits(4)) % 11;
            bits = take_bits(4);
            imm8 = {{4{bits[3]}}, bits[3:0]};
            instr = {OP_BCOND, cond_list[idx], imm8};
            if (cond_taken(cond_list[idx], model_flags)) begin
                model_pc = model_pc + {{8{imm8[7]}}, imm8};
            end
        end else begin
            instr = {OP_MEM, rd, (kind < 12) ? EXT_LOAD : EXT_STORE, rs};
            load_pending  = (kind < 12);
            store_pending = (kind >= 12);
            pend_rd = rd;
            pend_rs = rs;
        end
    endtask

    // A data transfer follows each LOAD or STORE, every other request is a fetch
    task automatic serve_request();
        if (load_pending) begin
            compare_addr("load mem_addr", mem_addr, model_regs[pend_rs]);
            compare_bit("mem_we", mem_we, 1'b0);
            resp_word = take_bits(16);
            model_regs[pend_rd] = resp_word;
            load_pending = 1'b0;
        end else if (store_pending) begin
            compare_addr("store mem_addr", mem_addr, model_regs[pend_rd]);
            compare_bit("mem_we", mem_we, 1'b1);
            compare_word("mem_wdata", mem_wdata, model_regs[pend_rs]);
            store_pending = 1'b0;
        end else begin
            compare_addr("fetch mem_addr", mem_addr, model_pc);
            compare_bit("mem_we", mem_we, 1'b0);
            compare_flags("status_flags", status_flags, model_flags);
            issue_instruction(resp_word);
            fetch_count++;
        end
    endtask

    // Memory responder with random ack rise and fall delays of 0 to 3 cycles
    always @(negedge I_CLK) begin
        word_t bits;
        if (I_NRESET) begin
            if (mem_req && !req_seen) begin
                req_seen = 1'b1;
                req_addr = mem_addr;
                if (mem_ack) begin
                    report_failure("mem_req rose again while mem_ack was still high");
                end
                serve_request();
                bits = take_bits(2);
                ack_wait = bits[1:0];
            end
            if (mem_req && !mem_ack) begin
                if (ack_wait == 2'd0) begin
                    compare_addr("held mem_addr", mem_addr, req_addr);
                    mem_ack   <= 1'b1;
                    mem_rdata <= resp_word;
                end else begin
                    ack_wait = ack_wait - 2'd1;
                end
            end else if (!mem_req && mem_ack) begin
                if (req_seen) begin
                    req_seen  = 1'b0;
                    bits      = take_bits(2);
                    drop_wait = bits[1:0];
                end
                if (drop_wait == 2'd0) begin
                    mem_ack <= 1'b0;
                end else begin
                    drop_wait = drop_wait - 2'd1;
                end
            end
        end
    end

    always @(posedge I_CLK) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles: the core stopped fetching at %0d of %0d",
                     cycle_count, fetch_count, N_INSTR);
            print_error_counts();
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        for (int i = 0; i < 16; i++) begin
            model_regs[i] = 16'h0000;
        end
        repeat (3) @(posedge I_CLK);
        @(negedge I_CLK);
        compare_bit("mem_req", mem_req, 1'b0);
        compare_flags("status_flags", status_flags, '0);
        I_NRESET = 1'b1;
        while (fetch_count < N_INSTR) begin
            @(posedge I_CLK);
        end
        print_error_counts();
        if (mismatch_count == 0 && protocol_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
